/* hw/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // ************************************************************************
    // sizes
    // ************************************************************************

    localparam int MEMORY_SIZE = 256;    // bytes, shared by code and data.
    localparam int ADDR_W      = 8;      // log2 of MEMORY_SIZE.
    localparam int XLEN        = 32;

    localparam int IQ_DEPTH = 4;         // instruction queue entries.
    localparam int LQ_DEPTH = 4;         // load queue entries.

    // ************************************************************************
    // access width and queue payloads
    // ************************************************************************

    typedef enum logic [1:0] {
        BYTE      = 2'b00,
        HALF_WORD = 2'b01,
        WORD      = 2'b10
    } width_t;

    // one fetched word together with the pc it came from.
    typedef struct packed {
        logic [XLEN - 1:0] pc;
        logic [XLEN - 1:0] instruction;
    } fetch_entry_t;

    typedef struct packed {
        logic [XLEN - 1:0] value;        // already sign or zero extended.
    } load_entry_t;

endpackage : mem_pkg

`default_nettype wire

/* hw/system_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module system_memory (
    input  wire                             clk_i,
    input  wire                             rst_n_i,

    // data load channel.
    input  wire                             load_i,
    input  wire [mem_pkg::ADDR_W - 1:0]     load_addr_i,
    output logic                            load_valid_o,
    output logic [mem_pkg::XLEN - 1:0]      load_data_o,

    // data store channel.
    input  wire                             store_i,
    input  wire [mem_pkg::ADDR_W - 1:0]     store_addr_i,
    input  wire mem_pkg::width_t            store_width_i,
    input  wire [mem_pkg::XLEN - 1:0]       store_data_i,
    output logic                            store_done_o,

    // instruction channel.
    input  wire                             fetch_i,
    input  wire                             invalidate_i,
    input  wire [mem_pkg::ADDR_W - 1:0]     fetch_addr_i,
    output logic [mem_pkg::XLEN - 1:0]      fetch_instruction_o,
    output logic                            fetch_valid_o
);

    typedef logic [mem_pkg::ADDR_W - 1:0] addr_t;

    logic [7:0] memory [mem_pkg::MEMORY_SIZE] = '{default: 8'h00};

    addr_t      load_addr_q;
    addr_t      fetch_addr;
    logic [2:0] store_bytes;
    logic       fetch_valid_q;

    // four little-endian bytes starting at base, wrapping at the top.
    function automatic logic [mem_pkg::XLEN - 1:0] read_word(input addr_t base);
        logic [mem_pkg::XLEN - 1:0] word;
        for (int i = 0; i < 4; i++) begin
            word[8 * i +: 8] = memory[addr_t'(base + i)];
        end
        return word;
    endfunction

    // ************************************************************************
    // data channel
    // ************************************************************************

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            load_valid_o <= 1'b0;
        end else begin
            load_valid_o <= load_i;
        end
        if (load_i) begin
            load_addr_q <= {load_addr_i[mem_pkg::ADDR_W - 1:2], 2'b00};  // word aligned.
        end
    end

    always_comb begin
        load_data_o = read_word(load_addr_q);
    end

    always_comb begin
        case (store_width_i)
            mem_pkg::BYTE:      store_bytes = 3'd1;
            mem_pkg::HALF_WORD: store_bytes = 3'd2;
            mem_pkg::WORD:      store_bytes = 3'd4;
            default:            store_bytes = 3'd0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (store_i) begin
            for (int i = 0; i < 4; i++) begin
                if (i < store_bytes) begin
                    memory[addr_t'(store_addr_i + i)] <= store_data_i[8 * i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            store_done_o <= 1'b0;
        end else begin
            store_done_o <= store_i;    // one cycle pulse after the write.
        end
    end

    // ************************************************************************
    // instruction channel
    // ************************************************************************

    assign fetch_addr = {fetch_addr_i[mem_pkg::ADDR_W - 1:1], 1'b0};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fetch_valid_q <= 1'b0;
        end else begin
            fetch_valid_q <= fetch_i;
        end
        fetch_instruction_o <= read_word(fetch_addr);
    end

    // a response still in flight is dropped while invalidate is high.
    assign fetch_valid_o = fetch_valid_q & ~invalidate_i;

    store_half_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        store_i && store_width_i == mem_pkg::HALF_WORD |-> !store_addr_i[0]);

    store_word_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        store_i && store_width_i == mem_pkg::WORD |-> store_addr_i[1:0] == 2'b00);

endmodule : system_memory

`default_nettype wire

/* hw/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
    input  wire                                       clk_i,
    input  wire                                       rst_n_i,

    input  wire                                       start_i,
    input  wire [mem_pkg::XLEN - 1:0]                 start_pc_i,
    input  wire                                       redirect_i,
    input  wire [mem_pkg::XLEN - 1:0]                 redirect_pc_i,
    input  wire [$clog2(mem_pkg::IQ_DEPTH + 1) - 1:0] level_i,

    // memory side.
    output logic                                      fetch_o,
    output logic [mem_pkg::ADDR_W - 1:0]              fetch_addr_o,
    output logic                                      invalidate_o,
    input  wire                                       fetch_valid_i,
    input  wire [mem_pkg::XLEN - 1:0]                 fetch_instruction_i,

    // instruction queue side.
    output logic                                      flush_o,
    output logic                                      push_o,
    output mem_pkg::fetch_entry_t                     entry_o
);

    logic [mem_pkg::XLEN - 1:0] pc_q;
    logic [mem_pkg::XLEN - 1:0] inflight_pc_q;
    logic                       running_q;
    logic                       inflight_q;
    logic                       has_space;

    // the fetch in flight already owns a slot in the queue.
    assign has_space = (level_i + inflight_q) < mem_pkg::IQ_DEPTH;

    // no issue in the cycle the pc is being (re)loaded.
    assign fetch_o      = running_q & has_space & ~start_i & ~redirect_i;
    assign fetch_addr_o = pc_q[mem_pkg::ADDR_W - 1:0];

    assign invalidate_o = redirect_i;
    assign flush_o      = redirect_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q       <= '0;
            running_q  <= 1'b0;
            inflight_q <= 1'b0;
        end else begin
            inflight_q <= fetch_o;
            if (redirect_i) begin
                pc_q      <= redirect_pc_i;
                running_q <= 1'b1;
            end else if (start_i) begin
                pc_q      <= start_pc_i;
                running_q <= 1'b1;
            end else if (fetch_o) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_o) begin
            inflight_pc_q <= pc_q;
        end
    end

    // every unmasked response goes straight into the queue.
    assign push_o              = fetch_valid_i;
    assign entry_o.pc          = inflight_pc_q;
    assign entry_o.instruction = fetch_instruction_i;

endmodule : fetch_unit

`default_nettype wire

/* hw/sync_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  wire                             clk_i,
    input  wire                             rst_n_i,

    input  wire                             flush_i,
    input  wire                             push_i,
    input  wire payload_t                   push_data_i,
    input  wire                             pop_i,

    output logic                            valid_o,
    output payload_t                        head_o,
    output logic [$clog2(DEPTH + 1) - 1:0]  level_o
);

    payload_t                         storage_q [DEPTH];
    logic [$clog2(DEPTH) - 1:0]       rd_ptr_q;
    logic [$clog2(DEPTH) - 1:0]       wr_ptr_q;
    logic [$clog2(DEPTH + 1) - 1:0]   count_q;
    logic                             do_push;
    logic                             do_pop;

    assign do_push = push_i & ~flush_i;
    assign do_pop  = pop_i & valid_o & ~flush_i;     // pop on empty is ignored.

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            storage_q[wr_ptr_q] <= push_data_i;
        end
    end

    assign valid_o = (count_q != '0);
    assign head_o  = storage_q[rd_ptr_q];
    assign level_o = count_q;

    // producers count credit, so a full queue never sees a push.
    no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        do_push |-> count_q < DEPTH);

endmodule : sync_fifo

`default_nettype wire

/* hw/load_store_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module load_store_unit (
    input  wire                                       clk_i,
    input  wire                                       rst_n_i,

    // requests from the core side.
    input  wire                                       load_i,
    input  wire                                       store_i,
    input  wire [mem_pkg::ADDR_W - 1:0]               addr_i,
    input  wire mem_pkg::width_t                      width_i,
    input  wire                                       unsigned_i,
    input  wire [mem_pkg::XLEN - 1:0]                 store_data_i,
    output logic                                      load_ready_o,
    output logic                                      store_done_o,

    // memory side.
    output logic                                      mem_load_o,
    output logic                                      mem_store_o,
    output logic [mem_pkg::ADDR_W - 1:0]              mem_addr_o,
    output mem_pkg::width_t                           mem_width_o,
    output logic [mem_pkg::XLEN - 1:0]                mem_store_data_o,
    input  wire                                       mem_load_valid_i,
    input  wire [mem_pkg::XLEN - 1:0]                 mem_load_data_i,
    input  wire                                       mem_store_done_i,

    // load queue side.
    input  wire [$clog2(mem_pkg::LQ_DEPTH + 1) - 1:0] level_i,
    output logic                                      push_o,
    output mem_pkg::load_entry_t                      entry_o
);

    logic [1:0]      offset_q;
    mem_pkg::width_t width_q;
    logic            unsigned_q;
    logic            inflight_q;
    logic [7:0]      sel_byte;
    logic [15:0]     sel_half;
    logic            sign_bit;

    // ************************************************************************
    // request path
    // ************************************************************************

    assign mem_load_o       = load_i;
    assign mem_store_o      = store_i;
    assign mem_addr_o       = addr_i;
    assign mem_width_o      = width_i;
    assign mem_store_data_o = store_data_i;
    assign store_done_o     = mem_store_done_i;

    // a load in flight already holds a slot in the queue.
    assign load_ready_o = (level_i + inflight_q) < mem_pkg::LQ_DEPTH;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            inflight_q <= 1'b0;
        end else begin
            inflight_q <= load_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            offset_q   <= addr_i[1:0];
            width_q    <= width_i;
            unsigned_q <= unsigned_i;
        end
    end

    // ************************************************************************
    // response path
    // ************************************************************************

    assign sel_byte = mem_load_data_i[8 * offset_q +: 8];
    assign sel_half = offset_q[1] ? mem_load_data_i[31:16] : mem_load_data_i[15:0];

    always_comb begin
        sign_bit = 1'b0;
        case (width_q)
            mem_pkg::BYTE: begin
                sign_bit      = sel_byte[7] & ~unsigned_q;
                entry_o.value = {{(mem_pkg::XLEN - 8){sign_bit}}, sel_byte};
            end
            mem_pkg::HALF_WORD: begin
                sign_bit      = sel_half[15] & ~unsigned_q;
                entry_o.value = {{(mem_pkg::XLEN - 16){sign_bit}}, sel_half};
            end
            default: entry_o.value = mem_load_data_i;   // whole word.
        endcase
    end

    assign push_o = mem_load_valid_i;

    no_load_and_store: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(load_i && store_i));

    load_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_i |-> (width_i != mem_pkg::HALF_WORD || !addr_i[0]) &&
                   (width_i != mem_pkg::WORD || addr_i[1:0] == 2'b00));

    // the queue credit must be available before a load is sent.
    load_only_when_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_i |-> load_ready_o);

endmodule : load_store_unit

`default_nettype wire

/* hw/memory_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module memory_subsystem (
    input  wire                         clk_i,
    input  wire                         rst_n_i,

    // fetch side.
    input  wire                         start_i,
    input  wire [mem_pkg::XLEN - 1:0]   start_pc_i,
    input  wire                         redirect_i,
    input  wire [mem_pkg::XLEN - 1:0]   redirect_pc_i,
    input  wire                         instr_pop_i,
    output logic                        instr_valid_o,
    output logic [mem_pkg::XLEN - 1:0]  instr_pc_o,
    output logic [mem_pkg::XLEN - 1:0]  instr_o,

    // data side.
    input  wire                         load_i,
    input  wire                         store_i,
    input  wire [mem_pkg::ADDR_W - 1:0] addr_i,
    input  wire mem_pkg::width_t        width_i,
    input  wire                         unsigned_i,
    input  wire [mem_pkg::XLEN - 1:0]   store_data_i,
    output logic                        load_ready_o,
    output logic                        store_done_o,
    output logic                        load_valid_o,
    output logic [mem_pkg::XLEN - 1:0]  load_data_o,
    input  wire                         load_pop_i
);

    logic                                     fetch, invalidate, fetch_valid;
    logic [mem_pkg::ADDR_W - 1:0]             fetch_addr;
    logic [mem_pkg::XLEN - 1:0]               fetch_instruction;
    logic                                     iq_flush, iq_push;
    logic [$clog2(mem_pkg::IQ_DEPTH + 1) - 1:0] iq_level;
    mem_pkg::fetch_entry_t                    iq_entry, iq_head;

    logic                                     mem_load, mem_store, mem_load_valid;
    logic                                     mem_store_done;
    logic [mem_pkg::ADDR_W - 1:0]             mem_addr;
    mem_pkg::width_t                          mem_width;
    logic [mem_pkg::XLEN - 1:0]               mem_store_data, mem_load_data;
    logic                                     lq_push;
    logic [$clog2(mem_pkg::LQ_DEPTH + 1) - 1:0] lq_level;
    mem_pkg::load_entry_t                     lq_entry, lq_head;

    system_memory system_memory_inst (
        .clk_i, .rst_n_i,
        .load_i(mem_load), .load_addr_i(mem_addr),
        .load_valid_o(mem_load_valid), .load_data_o(mem_load_data),
        .store_i(mem_store), .store_addr_i(mem_addr), .store_width_i(mem_width),
        .store_data_i(mem_store_data), .store_done_o(mem_store_done),
        .fetch_i(fetch), .invalidate_i(invalidate), .fetch_addr_i(fetch_addr),
        .fetch_instruction_o(fetch_instruction), .fetch_valid_o(fetch_valid)
    );

    fetch_unit fetch_unit_inst (
        .clk_i, .rst_n_i, .start_i, .start_pc_i, .redirect_i, .redirect_pc_i,
        .level_i(iq_level), .fetch_o(fetch), .fetch_addr_o(fetch_addr),
        .invalidate_o(invalidate), .fetch_valid_i(fetch_valid),
        .fetch_instruction_i(fetch_instruction),
        .flush_o(iq_flush), .push_o(iq_push), .entry_o(iq_entry)
    );

    sync_fifo #(.payload_t(mem_pkg::fetch_entry_t), .DEPTH(mem_pkg::IQ_DEPTH))
    instruction_queue (
        .clk_i, .rst_n_i, .flush_i(iq_flush), .push_i(iq_push), .push_data_i(iq_entry),
        .pop_i(instr_pop_i), .valid_o(instr_valid_o), .head_o(iq_head), .level_o(iq_level)
    );

    load_store_unit load_store_unit_inst (
        .clk_i, .rst_n_i, .load_i, .store_i, .addr_i, .width_i, .unsigned_i, .store_data_i,
        .load_ready_o, .store_done_o,
        .mem_load_o(mem_load), .mem_store_o(mem_store), .mem_addr_o(mem_addr),
        .mem_width_o(mem_width), .mem_store_data_o(mem_store_data),
        .mem_load_valid_i(mem_load_valid), .mem_load_data_i(mem_load_data),
        .mem_store_done_i(mem_store_done),
        .level_i(lq_level), .push_o(lq_push), .entry_o(lq_entry)
    );

    // the load queue is never flushed.
    sync_fifo #(.payload_t(mem_pkg::load_entry_t), .DEPTH(mem_pkg::LQ_DEPTH))
    load_queue (
        .clk_i, .rst_n_i, .flush_i(1'b0), .push_i(lq_push), .push_data_i(lq_entry),
        .pop_i(load_pop_i), .valid_o(load_valid_o), .head_o(lq_head), .level_o(lq_level)
    );

    assign instr_pc_o  = iq_head.pc;
    assign instr_o     = iq_head.instruction;
    assign load_data_o = lq_head.value;

endmodule : memory_subsystem

`default_nettype wire

/* sim/memory_subsystem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module memory_subsystem_tb;

    // rough cycle count of each test.
    localparam int RESET_CYCLES    = 12;
    localparam int STORE_CYCLES    = 120;
    localparam int EXTEND_CYCLES   = 180;
    localparam int STREAM_CYCLES   = 120;
    localparam int REDIRECT_CYCLES = 40;
    localparam int CREDIT_CYCLES   = 60;
    // the watchdog allows twice the sum.
    localparam int TIMEOUT_CYCLES  = 2 * (RESET_CYCLES + STORE_CYCLES + EXTEND_CYCLES +
                                          STREAM_CYCLES + REDIRECT_CYCLES + CREDIT_CYCLES);

    logic                       clk_i;
    logic                       rst_n_i;
    logic                       start_i;
    logic [mem_pkg::XLEN - 1:0] start_pc_i;
    logic                       redirect_i;
    logic [mem_pkg::XLEN - 1:0] redirect_pc_i;
    logic                       instr_pop_i;
    logic                       instr_valid_o;
    logic [mem_pkg::XLEN - 1:0] instr_pc_o;
    logic [mem_pkg::XLEN - 1:0] instr_o;
    logic                       load_i;
    logic                       store_i;
    logic [mem_pkg::ADDR_W - 1:0] addr_i;
    mem_pkg::width_t            width_i;
    logic                       unsigned_i;
    logic [mem_pkg::XLEN - 1:0] store_data_i;
    logic                       load_ready_o;
    logic                       store_done_o;
    logic                       load_valid_o;
    logic [mem_pkg::XLEN - 1:0] load_data_o;
    logic                       load_pop_i;

    logic [7:0] model [mem_pkg::MEMORY_SIZE];    // model of the shared byte array.

    memory_subsystem memory_subsystem_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("timeout: the tests did not finish in %0t", $time);
        fail_run("watchdog timeout");
    end

    // ************************************************************************
    // helpers
    // ************************************************************************

    task automatic fail_run(input string reason);
        $display("Some tests failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            fail_run("value mismatch");
        end
    endtask

    function automatic logic [31:0] model_word(input logic [7:0] addr);
        logic [31:0] word;
        for (int i = 0; i < 4; i++) begin
            word[8 * i +: 8] = model[8'(addr + i)];    // little endian.
        end
        return word;
    endfunction

    function automatic logic [31:0] expected_load(input logic [7:0] addr,
                                                  input mem_pkg::width_t width,
                                                  input logic uns);
        logic [7:0]  b;
        logic [15:0] h;
        b = model[addr];
        h = {model[8'(addr + 1)], model[addr]};
        case (width)
            mem_pkg::BYTE:      return uns ? {24'h0, b} : {{24{b[7]}}, b};
            mem_pkg::HALF_WORD: return uns ? {16'h0, h} : {{16{h[15]}}, h};
            default:            return model_word(addr);
        endcase
    endfunction

    task automatic store_value(input logic [7:0] addr, input mem_pkg::width_t width,
                               input logic [31:0] data);
        int nbytes;
        nbytes = (width == mem_pkg::WORD) ? 4 : (width == mem_pkg::HALF_WORD) ? 2 : 1;
        @(posedge clk_i);
        store_i      <= 1'b1;
        addr_i       <= addr;
        width_i      <= width;
        store_data_i <= data;
        @(posedge clk_i);
        store_i <= 1'b0;
        @(negedge clk_i);
        compare_value("store_done_o", 1'b1, store_done_o);
        @(negedge clk_i);
        compare_value("store_done_o", 1'b0, store_done_o);    // one cycle pulse.
        for (int i = 0; i < nbytes; i++) begin
            model[8'(addr + i)] = data[8 * i +: 8];
        end
    endtask

    task automatic issue_load(input logic [7:0] addr, input mem_pkg::width_t width,
                              input logic uns);
        @(posedge clk_i);
        load_i     <= 1'b1;
        addr_i     <= addr;
        width_i    <= width;
        unsigned_i <= uns;
        @(posedge clk_i);
        load_i <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic pop_load(input logic [31:0] expected);
        while (!load_valid_o) @(negedge clk_i);
        compare_value("load_data_o", expected, load_data_o);
        @(posedge clk_i);
        load_pop_i <= 1'b1;
        @(posedge clk_i);
        load_pop_i <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic load_and_check(input logic [7:0] addr, input mem_pkg::width_t width,
                                  input logic uns);
        logic [31:0] expected;
        expected = expected_load(addr, width, uns);
        issue_load(addr, width, uns);
        pop_load(expected);
    endtask

    task automatic pop_instr(input logic [31:0] pc);
        while (!instr_valid_o) @(negedge clk_i);
        compare_value("instr_pc_o", pc, instr_pc_o);
        compare_value("instr_o", model_word(pc[7:0]), instr_o);
        @(posedge clk_i);
        instr_pop_i <= 1'b1;
        @(posedge clk_i);
        instr_pop_i <= 1'b0;
        @(negedge clk_i);
    endtask

    // ************************************************************************
    // tests
    // ************************************************************************

    task automatic reset_state_check();
        @(negedge clk_i);
        compare_value("instr_valid_o", 1'b0, instr_valid_o);
        compare_value("load_valid_o", 1'b0, load_valid_o);
        compare_value("store_done_o", 1'b0, store_done_o);
        compare_value("load_ready_o", 1'b1, load_ready_o);
    endtask

    task automatic store_width_merge();
        logic [7:0] base;
        for (int n = 0; n < 6; n++) begin
            base = 8'($urandom_range(31)) << 2;
            store_value(base, mem_pkg::WORD, $urandom());
            store_value(base + 8'($urandom_range(1) * 2), mem_pkg::HALF_WORD, $urandom());
            store_value(base + 8'($urandom_range(3)), mem_pkg::BYTE, $urandom());
            load_and_check(base, mem_pkg::WORD, 1'b0);    // merged bytes.
        end
    endtask

    task automatic load_extension_sweep();
        logic [7:0]  base;
        logic [31:0] data;
        base = 8'h40 + (8'($urandom_range(15)) << 2);
        for (int n = 0; n < 2; n++) begin
            data = (n == 0) ? ($urandom() | 32'h8080_8080) : ($urandom() & 32'h7f7f_7f7f);
            store_value(base, mem_pkg::WORD, data);
            for (int off = 0; off < 4; off++) begin
                load_and_check(base + 8'(off), mem_pkg::BYTE, 1'b0);
                load_and_check(base + 8'(off), mem_pkg::BYTE, 1'b1);
                if (off % 2 == 0) begin
                    load_and_check(base + 8'(off), mem_pkg::HALF_WORD, 1'b0);
                    load_and_check(base + 8'(off), mem_pkg::HALF_WORD, 1'b1);
                end
            end
        end
    endtask

    task automatic instruction_stream_run();
        for (int k = 0; k < 8; k++) begin
            store_value(8'h80 + 8'(4 * k), mem_pkg::WORD, $urandom());
        end
        @(posedge clk_i);
        start_i    <= 1'b1;
        start_pc_i <= 32'h80;
        @(posedge clk_i);
        start_i <= 1'b0;
        @(negedge clk_i);
        compare_value("instr_valid_o", 1'b0, instr_valid_o);
        @(negedge clk_i);
        compare_value("instr_valid_o", 1'b0, instr_valid_o);
        @(negedge clk_i);
        compare_value("instr_valid_o", 1'b1, instr_valid_o);    // pc load, issue, response.
        for (int k = 0; k < 6; k++) begin
            pop_instr(32'h80 + 32'(4 * k));
            repeat ($urandom_range(3)) @(negedge clk_i);
        end
        repeat (10) @(negedge clk_i);
        compare_value("iq_level", mem_pkg::IQ_DEPTH, memory_subsystem_inst.iq_level);
        pop_instr(32'h98);
        pop_instr(32'h9c);
    endtask

    task automatic redirect_flush_run();
        @(posedge clk_i);
        redirect_i    <= 1'b1;
        redirect_pc_i <= 32'h88;
        @(posedge clk_i);
        redirect_i <= 1'b0;
        @(negedge clk_i);
        compare_value("instr_valid_o", 1'b0, instr_valid_o);    // queue flushed.
        for (int k = 0; k < 4; k++) begin
            pop_instr(32'h88 + 32'(4 * k));
        end
    endtask

    task automatic load_credit_run();
        logic [7:0]  addr;
        logic [31:0] data;
        logic [31:0] expected [mem_pkg::LQ_DEPTH + 1];
        int          issued;
        // words with distinct low bytes at known addresses.
        for (int k = 0; k <= mem_pkg::LQ_DEPTH; k++) begin
            data = {24'($urandom()), 8'(k)};
            store_value(8'hc0 + 8'(4 * k), mem_pkg::WORD, data);
        end
        issued = 0;
        @(negedge clk_i);
        while (load_ready_o && issued <= mem_pkg::LQ_DEPTH) begin
            addr             = 8'hc0 + 8'(4 * issued);
            expected[issued] = model_word(addr);
            issue_load(addr, mem_pkg::WORD, 1'b0);
            issued++;
        end
        compare_value("issued loads", mem_pkg::LQ_DEPTH, issued);
        for (int k = 0; k < mem_pkg::LQ_DEPTH; k++) begin
            pop_load(expected[k]);    // issue order.
        end
        compare_value("load_ready_o", 1'b1, load_ready_o);
    endtask

    initial begin
        rst_n_i       = 1'b0;
        start_i       = 1'b0;
        start_pc_i    = '0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        instr_pop_i   = 1'b0;
        load_i        = 1'b0;
        store_i       = 1'b0;
        addr_i        = '0;
        width_i       = mem_pkg::BYTE;
        unsigned_i    = 1'b0;
        store_data_i  = '0;
        load_pop_i    = 1'b0;
        for (int i = 0; i < mem_pkg::MEMORY_SIZE; i++) begin
            model[i] = 8'h00;
        end
        void'($urandom(82));
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        reset_state_check();
        store_width_merge();
        load_extension_sweep();
        instruction_stream_run();
        redirect_flush_run();
        load_credit_run();
        $display("All tests passed");
        $finish;
    end

endmodule : memory_subsystem_tb

`default_nettype wire

/* memory_subsystem.f */
hw/mem_pkg.sv
hw/system_memory.sv
hw/fetch_unit.sv
hw/sync_fifo.sv
hw/load_store_unit.sv
hw/memory_subsystem.sv
sim/memory_subsystem_tb.sv
